//--- common/tile_pkg.sv
`default_nettype none

package tile_pkg;

  // tile states as stored in the map memory
  typedef enum logic [3:0] {
    border,          // forced for every pixel outside the grid
    no_blk,
    perm_blk,
    destroyable_blk,
    player,
    enemy,
    bomb,
    explosion,
    power_up
  } tile_state_e;

  // configuration register map
  typedef enum logic [1:0] {
    CFG_PLAYER_X   = 2'd0,
    CFG_PLAYER_Y   = 2'd1,
    CFG_PLAYER_RGB = 2'd2,
    CFG_BORDER_RGB = 2'd3
  } cfg_reg_e;

  typedef struct packed {
    logic [3:0] r;
    logic [3:0] g;
    logic [3:0] b;
  } rgb_t; // 12 bit colour, r in the msbs

  typedef struct packed {
    logic [10:0] x;
    logic [9:0]  y;
  } pix_pos_t;

  typedef struct packed {
    logic right;
    logic left;
    logic down;
    logic up;
  } obstacle_t; // one flag per side of the player tile

  localparam rgb_t PAL_BG    = 12'h000; // black
  localparam rgb_t PAL_PERM  = 12'hfff; // white
  localparam rgb_t PAL_DESTR = 12'h00f; // blue
  localparam rgb_t PAL_ENEMY = 12'hf33; // red-pink
  localparam rgb_t PAL_BOMB  = 12'h333; // dark grey
  localparam rgb_t PAL_EXPL  = 12'hf00; // red
  localparam rgb_t PAL_POWER = 12'h0f0; // green
  localparam rgb_t PAL_BUG   = 12'hff0; // yellow means a bad state code reached the renderer

  // 1280x800 reduced blanking scan, sync pulses active high
  localparam int H_ACTIVE = 1280;
  localparam int H_FRONT  = 48;
  localparam int H_SYNC   = 32;
  localparam int H_TOTAL  = 1440; // back porch of 80
  localparam int V_ACTIVE = 800;
  localparam int V_FRONT  = 3;
  localparam int V_SYNC   = 6;
  localparam int V_TOTAL  = 823;  // back porch of 14

  localparam int PIPE_DELAY = 2; // scan position to colour, in clocks

endpackage

`default_nettype wire

//--- hw/video_timing.sv
`timescale 1ns/1ps
`default_nettype none

module video_timing (
  input  wire logic              clk,
  input  wire logic              i_rst_n,
  output tile_pkg::pix_pos_t     o_pos,
  output logic                   o_hsync,
  output logic                   o_vsync,
  output logic                   o_active
);

  import tile_pkg::*;

  // strobes decoded from the counters, travel together through the delay
  typedef struct packed {
    logic active;
    logic hsync;
    logic vsync;
  } strobe_t;

  logic [10:0] h_cnt;
  logic [9:0]  v_cnt;
  logic        h_last; // last clock of a line
  strobe_t     strb_raw;
  strobe_t     strb_d1;
  strobe_t     strb_d2;

  assign h_last = (h_cnt == 11'(H_TOTAL - 1));

  always_ff @(posedge clk)
  begin
    if (!i_rst_n)
    begin
      h_cnt <= '0;
      v_cnt <= '0;
    end
    else
    begin
      h_cnt <= h_last ? '0 : h_cnt + 11'd1;
      if (h_last) // vertical steps once per line
        v_cnt <= (v_cnt == 10'(V_TOTAL - 1)) ? '0 : v_cnt + 10'd1;
    end
  end

  assign o_pos = '{x: h_cnt, y: v_cnt};

  always_comb
  begin
    strb_raw.active = (h_cnt < 11'(H_ACTIVE)) && (v_cnt < 10'(V_ACTIVE));
    strb_raw.hsync  = (h_cnt >= 11'(H_ACTIVE + H_FRONT)) &&
                      (h_cnt <  11'(H_ACTIVE + H_FRONT + H_SYNC));
    strb_raw.vsync  = (v_cnt >= 10'(V_ACTIVE + V_FRONT)) &&
                      (v_cnt <  10'(V_ACTIVE + V_FRONT + V_SYNC));
  end

  // two stages so the strobes line up with the renderer colour
  always_ff @(posedge clk)
  begin
    if (!i_rst_n)
    begin
      strb_d1 <= '0;
      strb_d2 <= '0;
    end
    else
    begin
      strb_d1 <= strb_raw;
      strb_d2 <= strb_d1;
    end
  end

  assign o_active = strb_d2.active;
  assign o_hsync  = strb_d2.hsync;
  assign o_vsync  = strb_d2.vsync;

  a_cnt_range : assert property (@(posedge clk) disable iff (!i_rst_n)
    (h_cnt < 11'(H_TOTAL)) && (v_cnt < 10'(V_TOTAL)));

endmodule

`default_nettype wire

//--- hw/map_mem.sv
`timescale 1ns/1ps
`default_nettype none

module map_mem #(
  parameter  int NUM_COL    = 19,
  parameter  int NUM_ROW    = 11,
  localparam int MAP_ADDR_W = $clog2(NUM_COL * NUM_ROW)
) (
  input  wire logic                   clk,
  input  wire logic                   i_we,
  input  wire logic [MAP_ADDR_W-1:0]  i_waddr,
  input  tile_pkg::tile_state_e       i_wstate,
  input  wire logic [MAP_ADDR_W-1:0]  i_raddr,
  output tile_pkg::tile_state_e       o_rstate
);

  import tile_pkg::*;

  localparam int NUM_TILES = NUM_COL * NUM_ROW;

  // one state per tile, row major, contents left to game logic
  tile_state_e mem [NUM_TILES];

  always_ff @(posedge clk)
  begin
    if (i_we)
      mem[i_waddr] <= i_wstate; // seen by a read from the next cycle
  end

  // registered read, data lands one clock after the address
  always_ff @(posedge clk)
  begin
    o_rstate <= mem[i_raddr];
  end

  a_waddr_range : assert property (@(posedge clk)
    i_we |-> (i_waddr < MAP_ADDR_W'(NUM_TILES)));

endmodule

`default_nettype wire

//--- render/draw_cfg.sv
`timescale 1ns/1ps
`default_nettype none

module draw_cfg #(
  parameter int BRD_SIDE = 32,
  parameter int BRD_TOP  = 96
) (
  input  wire logic           clk,
  input  wire logic           i_rst_n,
  input  wire logic           i_we,
  input  tile_pkg::cfg_reg_e  i_addr,
  input  wire logic [15:0]    i_data,
  output tile_pkg::pix_pos_t  o_player_pos,
  output tile_pkg::rgb_t      o_player_rgb,
  output tile_pkg::rgb_t      o_border_rgb
);

  import tile_pkg::*;

  pix_pos_t player_pos_q;
  rgb_t     player_rgb_q;
  rgb_t     border_rgb_q;

  always_ff @(posedge clk)
  begin
    if (!i_rst_n)
    begin
      player_pos_q <= '{x: 11'(BRD_SIDE), y: 10'(BRD_TOP)}; // top left tile of the grid
      player_rgb_q <= PAL_BG;
      border_rgb_q <= '{r: 4'hf, g: 4'hf, b: 4'hf}; // white frame
    end
    else if (i_we)
    begin
      // only the low bits of the data word are kept
      case (i_addr)
        CFG_PLAYER_X:   player_pos_q.x <= i_data[10:0];
        CFG_PLAYER_Y:   player_pos_q.y <= i_data[9:0];
        CFG_PLAYER_RGB: player_rgb_q   <= i_data[11:0];
        CFG_BORDER_RGB: border_rgb_q   <= i_data[11:0];
      endcase
    end
  end

  assign o_player_pos = player_pos_q;
  assign o_player_rgb = player_rgb_q;
  assign o_border_rgb = border_rgb_q;

endmodule

`default_nettype wire

//--- render/tile_renderer.sv
`timescale 1ns/1ps
`default_nettype none

module tile_renderer #(
  parameter  int NUM_COL    = 19,
  parameter  int NUM_ROW    = 11,
  parameter  int BLK_LOG2   = 6,
  parameter  int BRD_SIDE   = 32,
  parameter  int BRD_TOP    = 96,
  parameter  int BRD_BOT    = 0,
  localparam int MAP_ADDR_W = $clog2(NUM_COL * NUM_ROW)
) (
  input  wire logic                   clk,
  input  wire logic                   i_rst_n,
  input  tile_pkg::pix_pos_t          i_pos,
  input  tile_pkg::tile_state_e       i_tile_state,
  input  tile_pkg::pix_pos_t          i_player_pos,
  input  tile_pkg::rgb_t              i_player_rgb,
  input  tile_pkg::rgb_t              i_border_rgb,
  output logic [MAP_ADDR_W-1:0]       o_map_raddr,
  output tile_pkg::rgb_t              o_rgb,
  output tile_pkg::obstacle_t         o_obstacle
);

  import tile_pkg::*;

  localparam int NUM_TILES = NUM_COL * NUM_ROW;
  localparam int BLK_SIZE  = 1 << BLK_LOG2; // tile edge in pixels

  logic                  outside;   // pixel not on the grid, cycle t
  logic                  outside_q; // aligned with the memory data, cycle t+1
  logic [10:0]           map_x;
  logic [9:0]            map_y;
  logic [MAP_ADDR_W-1:0] col;
  logic [MAP_ADDR_W-1:0] row;
  tile_state_e           st;        // drives the colour, cycle t+2

  always_comb
  begin
    outside = (i_pos.x < 11'(BRD_SIDE)) || (i_pos.x >= 11'(H_ACTIVE - BRD_SIDE)) ||
              (i_pos.y < 10'(BRD_TOP))  || (i_pos.y >= 10'(V_ACTIVE - BRD_BOT));
  end

  // grid relative position, wraps when outside but then the read is ignored
  assign map_x = i_pos.x - 11'(BRD_SIDE);
  assign map_y = i_pos.y - 10'(BRD_TOP);

  always_comb
  begin
    col         = MAP_ADDR_W'(map_x >> BLK_LOG2);
    row         = MAP_ADDR_W'(map_y >> BLK_LOG2);
    o_map_raddr = row * MAP_ADDR_W'(NUM_COL) + col; // row major, constant multiply
  end

  always_ff @(posedge clk)
  begin
    if (!i_rst_n)
      outside_q <= 1'b1;
    else
      outside_q <= outside;
  end

  always_ff @(posedge clk)
  begin
    if (!i_rst_n)
      st <= border;
    else if (outside_q)
      st <= border; // frame and blanking
    else
      st <= i_tile_state;
  end

  always_comb
  begin
    case (st)
      border:          o_rgb = i_border_rgb;
      no_blk:          o_rgb = PAL_BG;
      perm_blk:        o_rgb = PAL_PERM;
      destroyable_blk: o_rgb = PAL_DESTR;
      player:          o_rgb = i_player_rgb;
      enemy:           o_rgb = PAL_ENEMY;
      bomb:            o_rgb = PAL_BOMB;
      explosion:       o_rgb = PAL_EXPL;
      power_up:        o_rgb = PAL_POWER;
      default:         o_rgb = PAL_BUG; // codes 9..15 never written by the game
    endcase
  end

  // wall flags from the player tile corner, widened so x + tile cannot wrap
  always_comb
  begin
    o_obstacle.right = (int'(i_player_pos.x) + BLK_SIZE >= H_ACTIVE - BRD_SIDE);
    o_obstacle.left  = (int'(i_player_pos.x) <= BRD_SIDE);
    o_obstacle.down  = (int'(i_player_pos.y) + BLK_SIZE >= V_ACTIVE - BRD_BOT);
    o_obstacle.up    = (int'(i_player_pos.y) <= BRD_TOP);
  end

  // the grid geometry and the memory depth must agree
  a_raddr_range : assert property (@(posedge clk) disable iff (!i_rst_n)
    !outside |-> (o_map_raddr < MAP_ADDR_W'(NUM_TILES)));

endmodule

`default_nettype wire

//--- hw/tile_display_top.sv
`timescale 1ns/1ps
`default_nettype none

module tile_display_top #(
  parameter  int NUM_COL    = 19,
  parameter  int NUM_ROW    = 11,
  parameter  int BLK_LOG2   = 6,
  parameter  int BRD_SIDE   = 32,
  parameter  int BRD_TOP    = 96,
  parameter  int BRD_BOT    = 0,
  localparam int MAP_ADDR_W = $clog2(NUM_COL * NUM_ROW)
) (
  input  wire logic                   clk,
  input  wire logic                   i_rst_n,
  input  wire logic                   i_map_we,   // tile write from game logic
  input  wire logic [MAP_ADDR_W-1:0]  i_map_addr,
  input  tile_pkg::tile_state_e       i_map_state,
  input  wire logic                   i_cfg_we,   // register write
  input  tile_pkg::cfg_reg_e          i_cfg_addr,
  input  wire logic [15:0]            i_cfg_data,
  output tile_pkg::rgb_t              o_rgb,
  output logic                        o_hsync,
  output logic                        o_vsync,
  output logic                        o_active,
  output tile_pkg::obstacle_t         o_obstacle
);

  import tile_pkg::*;

  pix_pos_t              pos;
  logic [MAP_ADDR_W-1:0] map_raddr;
  tile_state_e           rd_state;
  pix_pos_t              player_pos;
  rgb_t                  player_rgb;
  rgb_t                  border_rgb;

  video_timing video_timing_i (
    .clk      (clk),
    .i_rst_n  (i_rst_n),
    .o_pos    (pos),
    .o_hsync  (o_hsync),
    .o_vsync  (o_vsync),
    .o_active (o_active)
  );

  map_mem #(.NUM_COL(NUM_COL), .NUM_ROW(NUM_ROW)) map_mem_i (
    .clk      (clk),
    .i_we     (i_map_we),
    .i_waddr  (i_map_addr),
    .i_wstate (i_map_state),
    .i_raddr  (map_raddr),
    .o_rstate (rd_state)
  );

  draw_cfg #(.BRD_SIDE(BRD_SIDE), .BRD_TOP(BRD_TOP)) draw_cfg_i (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_we         (i_cfg_we),
    .i_addr       (i_cfg_addr),
    .i_data       (i_cfg_data),
    .o_player_pos (player_pos),
    .o_player_rgb (player_rgb),
    .o_border_rgb (border_rgb)
  );

  tile_renderer #(
    .NUM_COL  (NUM_COL),
    .NUM_ROW  (NUM_ROW),
    .BLK_LOG2 (BLK_LOG2),
    .BRD_SIDE (BRD_SIDE),
    .BRD_TOP  (BRD_TOP),
    .BRD_BOT  (BRD_BOT)
  ) tile_renderer_i (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_pos        (pos),
    .i_tile_state (rd_state),
    .i_player_pos (player_pos),
    .i_player_rgb (player_rgb),
    .i_border_rgb (border_rgb),
    .o_map_raddr  (map_raddr),
    .o_rgb        (o_rgb),
    .o_obstacle   (o_obstacle)
  );

endmodule

`default_nettype wire

//--- tests/tb_tile_display.sv
`timescale 1ns/1ps
`default_nettype none

module tb_tile_display;

  import tile_pkg::*;

  localparam int NUM_COL    = 19;
  localparam int NUM_ROW    = 11;
  localparam int BLK_LOG2   = 6;
  localparam int BRD_SIDE   = 32;
  localparam int BRD_TOP    = 96;
  localparam int BRD_BOT    = 0;
  localparam int NUM_TILES  = NUM_COL * NUM_ROW;
  localparam int MAP_ADDR_W = $clog2(NUM_TILES);
  localparam int BLK_SIZE   = 1 << BLK_LOG2;
  localparam int RST_CYCLES = 5;
  localparam int UPD_CNT    = 24; // tiles rewritten between frames
  localparam int OBS_CNT    = 12; // player positions tried, six of them at the walls
  localparam int FRAME      = H_TOTAL * V_TOTAL;
  // three frames of scan plus all write and check cycles, then 10% on top
  localparam int WRITE_CYCLES = RST_CYCLES + (NUM_TILES + 1) + 2 * 2 + (UPD_CNT + 1) +
                                OBS_CNT * 2 * 4;
  localparam int MAX_CYCLES = (3 * FRAME + WRITE_CYCLES) * 11 / 10;

  logic                  clk;
  logic                  i_rst_n;
  logic                  i_map_we;
  logic [MAP_ADDR_W-1:0] i_map_addr;
  tile_state_e           i_map_state;
  logic                  i_cfg_we;
  cfg_reg_e              i_cfg_addr;
  logic [15:0]           i_cfg_data;
  rgb_t                  o_rgb;
  logic                  o_hsync;
  logic                  o_vsync;
  logic                  o_active;
  obstacle_t             o_obstacle;

  // reference model state
  tile_state_e model_map [NUM_TILES]; // tile states as written
  rgb_t        model_border;
  rgb_t        model_player_rgb;
  int          model_px;
  int          model_py;
  logic        map_valid;  // inside pixels are checked once every tile is written
  int          tile_cat;   // test that owns the inside pixel checks
  int          mh;         // scan position the DUT presents now
  int          mv;
  int          pd1_x;      // position one cycle back
  int          pd1_y;
  int          pd2_x;      // position whose colour is on o_rgb
  int          pd2_y;
  logic        v1;
  logic        v2;         // pd2 holds a position scanned after reset
  int          errs [6];   // mismatches per test
  int          pass_cnt;
  int          fail_cnt;
  int          cyc = 0;

  tile_display_top #(
    .NUM_COL  (NUM_COL),
    .NUM_ROW  (NUM_ROW),
    .BLK_LOG2 (BLK_LOG2),
    .BRD_SIDE (BRD_SIDE),
    .BRD_TOP  (BRD_TOP),
    .BRD_BOT  (BRD_BOT)
  ) tile_display_top_i (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_map_we    (i_map_we),
    .i_map_addr  (i_map_addr),
    .i_map_state (i_map_state),
    .i_cfg_we    (i_cfg_we),
    .i_cfg_addr  (i_cfg_addr),
    .i_cfg_data  (i_cfg_data),
    .o_rgb       (o_rgb),
    .o_hsync     (o_hsync),
    .o_vsync     (o_vsync),
    .o_active    (o_active),
    .o_obstacle  (o_obstacle)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk; // 20 ns period
  end

  // scan counters rebuilt from the totals, plus two cycles of delay
  always @(posedge clk)
  begin
    pd1_x <= mh;
    pd1_y <= mv;
    pd2_x <= pd1_x;
    pd2_y <= pd1_y;
    if (!i_rst_n)
    begin
      mh <= 0;
      mv <= 0;
      v1 <= 1'b0;
      v2 <= 1'b0;
    end
    else
    begin
      v1 <= 1'b1;
      v2 <= v1;
      if (mh == H_TOTAL - 1)
      begin
        mh <= 0;
        mv <= (mv == V_TOTAL - 1) ? 0 : mv + 1; // frame wrap
      end
      else
        mh <= mh + 1;
    end
  end

  always @(posedge clk)
  begin
    cyc <= cyc + 1;
    if (cyc >= MAX_CYCLES)
    begin
      $display("timeout: the run did not end within %0d clock cycles", MAX_CYCLES);
      $display("Test FAILED");
      $finish;
    end
  end

  function automatic rgb_t state_colour(input tile_state_e st);
    case (st)
      border:          return model_border;
      no_blk:          return PAL_BG;
      perm_blk:        return PAL_PERM;
      destroyable_blk: return PAL_DESTR;
      player:          return model_player_rgb;
      enemy:           return PAL_ENEMY;
      bomb:            return PAL_BOMB;
      explosion:       return PAL_EXPL;
      power_up:        return PAL_POWER;
      default:         return PAL_BUG;
    endcase
  endfunction

  function automatic logic is_outside(input int x, input int y);
    return (x < BRD_SIDE) || (x >= H_ACTIVE - BRD_SIDE) ||
           (y < BRD_TOP) || (y >= V_ACTIVE - BRD_BOT);
  endfunction

  function automatic int tile_index(input int x, input int y);
    return ((y - BRD_TOP) >> BLK_LOG2) * NUM_COL + ((x - BRD_SIDE) >> BLK_LOG2); // row major
  endfunction

  function automatic obstacle_t wall_flags(input int px, input int py);
    obstacle_t f;
    f.right = (px + BLK_SIZE >= H_ACTIVE - BRD_SIDE);
    f.left  = (px <= BRD_SIDE);
    f.down  = (py + BLK_SIZE >= V_ACTIVE - BRD_BOT);
    f.up    = (py <= BRD_TOP);
    return f;
  endfunction

  task automatic compare(input string name, input logic [31:0] exp_val,
                         input logic [31:0] act_val, input int cat);
    if (exp_val !== act_val)
    begin
      errs[cat]++;
      $display("CHECK FAILED at %0t ns: %s expected %0h, got %0h",
               $time, name, exp_val, act_val);
    end
  endtask

  // per pixel checks, runs for the whole simulation
  task automatic scan_checker();
    logic exp_active;
    logic exp_hs;
    logic exp_vs;
    forever
    begin
      @(negedge clk);
      exp_active = v2 && (pd2_x < H_ACTIVE) && (pd2_y < V_ACTIVE);
      exp_hs = v2 && (pd2_x >= H_ACTIVE + H_FRONT) && (pd2_x < H_ACTIVE + H_FRONT + H_SYNC);
      exp_vs = v2 && (pd2_y >= V_ACTIVE + V_FRONT) && (pd2_y < V_ACTIVE + V_FRONT + V_SYNC);
      compare("o_active", 32'(exp_active), 32'(o_active), 1);
      compare("o_hsync", 32'(exp_hs), 32'(o_hsync), 1);
      compare("o_vsync", 32'(exp_vs), 32'(o_vsync), 1);
      if (exp_active && is_outside(pd2_x, pd2_y))
        compare("o_rgb", 32'(model_border), 32'(o_rgb), 2); // frame pixel
      else if (exp_active && map_valid)
        compare("o_rgb", 32'(state_colour(model_map[tile_index(pd2_x, pd2_y)])),
                32'(o_rgb), tile_cat);
    end
  endtask

  // counts over one frame, started and ended in vertical blanking
  task automatic count_frame();
    logic prev_act;
    logic prev_hs;
    logic prev_vs;
    int   run;
    int   lines;
    int   hs_rise;
    int   vs_rise;
    @(negedge clk);
    prev_act = o_active;
    prev_hs  = o_hsync;
    prev_vs  = o_vsync;
    run      = 0;
    lines    = 0;
    hs_rise  = 0;
    vs_rise  = 0;
    repeat (FRAME)
    begin
      @(negedge clk);
      if (o_active)
        run++;
      else if (prev_act)
      begin
        compare("active cycles per line", H_ACTIVE, run, 1); // end of a run
        lines++;
        run = 0;
      end
      if (o_hsync && !prev_hs)
        hs_rise++;
      if (o_vsync && !prev_vs)
        vs_rise++;
      prev_act = o_active;
      prev_hs  = o_hsync;
      prev_vs  = o_vsync;
    end
    compare("active lines per frame", V_ACTIVE, lines, 1);
    compare("hsync pulses per frame", V_TOTAL, hs_rise, 1);
    compare("vsync pulses per frame", 1, vs_rise, 1);
  endtask

  task automatic map_write(input int addr, input tile_state_e st);
    @(posedge clk);
    i_map_we    <= 1'b1;
    i_map_addr  <= MAP_ADDR_W'(addr);
    i_map_state <= st;
    model_map[addr] = st;
  endtask

  task automatic cfg_write(input cfg_reg_e addr, input logic [15:0] data);
    @(posedge clk);
    i_cfg_we   <= 1'b1;
    i_cfg_addr <= addr;
    i_cfg_data <= data;
    @(posedge clk);
    i_cfg_we   <= 1'b0; // register has taken the value at this edge
    case (addr)
      CFG_PLAYER_X:   model_px = int'(data[10:0]);
      CFG_PLAYER_Y:   model_py = int'(data[9:0]);
      CFG_PLAYER_RGB: model_player_rgb = data[11:0];
      default:        model_border = data[11:0];
    endcase
  endtask

  task automatic check_walls();
    repeat (2) // flags must hold, not just appear
    begin
      @(negedge clk);
      compare("o_obstacle", 32'(wall_flags(model_px, model_py)), 32'(o_obstacle), 5);
    end
  endtask

  task automatic wait_line(input int line);
    do
      @(posedge clk);
    while (mv != line);
  endtask

  task automatic report_test(input int num, input string name);
    if (errs[num - 1] == 0)
    begin
      pass_cnt++;
      $display("test %0d %s: pass", num, name);
    end
    else
    begin
      fail_cnt++;
      $display("test %0d %s: fail, %0d mismatches", num, name, errs[num - 1]);
    end
  endtask

  initial
  begin
    int px;
    int py;
    int addr;
    int new_st;
    int total;
    void'($urandom(32'hd53e));
    i_rst_n     = 1'b0;
    i_map_we    = 1'b0;
    i_map_addr  = '0;
    i_map_state = border;
    i_cfg_we    = 1'b0;
    i_cfg_addr  = CFG_PLAYER_X;
    i_cfg_data  = '0;
    model_border     = 12'hfff; // reset values of the register block
    model_player_rgb = PAL_BG;
    model_px         = BRD_SIDE;
    model_py         = BRD_TOP;
    map_valid  = 1'b0;
    tile_cat   = 3;
    pass_cnt   = 0;
    fail_cnt   = 0;
    foreach (errs[i])
      errs[i] = 0;

    repeat (RST_CYCLES) @(posedge clk);
    i_rst_n <= 1'b1;
    @(negedge clk);
    compare("o_active", 0, 32'(o_active), 0);
    compare("o_hsync", 0, 32'(o_hsync), 0);
    compare("o_vsync", 0, 32'(o_vsync), 0);
    compare("o_obstacle", 32'(wall_flags(model_px, model_py)), 32'(o_obstacle), 0);
    report_test(1, "reset state");
    fork
      scan_checker();
    join_none

    // new border, player colour and a full map, all in vertical blanking
    wait_line(V_ACTIVE);
    cfg_write(CFG_BORDER_RGB, 16'($urandom_range(0, 4095)));
    cfg_write(CFG_PLAYER_RGB, 16'($urandom_range(0, 4095)));
    for (int t = 0; t < NUM_TILES; t++)
      map_write(t, tile_state_e'(4'($urandom_range(0, 8))));
    @(posedge clk);
    i_map_we <= 1'b0;
    map_valid = 1'b1;
    count_frame(); // scan counts while the checker covers every pixel
    report_test(2, "scan structure");
    report_test(3, "border colour");
    report_test(4, "tile colours");

    tile_cat = 4;
    for (int k = 0; k < UPD_CNT; k++)
    begin
      addr   = $urandom_range(0, NUM_TILES - 1);
      new_st = (int'(model_map[addr]) + 1 + $urandom_range(0, 7)) % 9; // always a new state
      map_write(addr, tile_state_e'(4'(new_st)));
    end
    @(posedge clk);
    i_map_we <= 1'b0;
    wait_line(0);
    wait_line(V_ACTIVE);
    report_test(5, "map update");

    for (int k = 0; k < OBS_CNT; k++)
    begin
      if (k < 6)
      begin
        // one below, at and one above each limit
        px = (k < 3) ? BRD_SIDE - 1 + k : H_ACTIVE - BRD_SIDE - BLK_SIZE - 4 + k;
        py = (k < 3) ? BRD_TOP - 1 + k : V_ACTIVE - BRD_BOT - BLK_SIZE - 4 + k;
      end
      else
      begin
        px = $urandom_range(0, 2047);
        py = $urandom_range(0, 1023);
      end
      cfg_write(CFG_PLAYER_X, 16'(px));
      check_walls();
      cfg_write(CFG_PLAYER_Y, 16'(py));
      check_walls();
    end
    report_test(6, "obstacle flags");

    total = 0;
    foreach (errs[i])
      total += errs[i];
    $display("tests passed: %0d, tests failed: %0d, mismatches: %0d",
             pass_cnt, fail_cnt, total);
    if (fail_cnt == 0 && total == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
common/tile_pkg.sv
hw/video_timing.sv
hw/map_mem.sv
render/draw_cfg.sv
render/tile_renderer.sv
hw/tile_display_top.sv
tests/tb_tile_display.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_tile_display
FILELIST  = src.f
OBJ_DIR   = obj_dir

SRCS = $(shell grep -v '^+' $(FILELIST))
SIM  = $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'Test OK'

clean:
	rm -rf $(OBJ_DIR)
